// ==== hw/oflow_core_pkg.sv ====
// ----------------------------------------------------------------------
// Pixel bus geometry of the optical-flow score stage.
// Shared by the SAD datapath and the testbench. Modules reference the
// constants by scoped name.
// ----------------------------------------------------------------------

`default_nettype none

package oflow_core_pkg;

	// one pixel of the current or the reference block.
	localparam int PIX_W = 8; // unsigned luma sample.

	// pixels packed into one bus word, lane 0 in the low bits.
	localparam int LANES = 4; // lanes processed in parallel.

	// full bus word carrying LANES pixels.
	localparam int WORD_W = PIX_W * LANES; // 32 bits.

endpackage

`default_nettype wire

// ==== hw/oflow_score_pkg.sv ====
// ----------------------------------------------------------------------
// Score and candidate index widths of the optical-flow score stage.
// Used by the minimum search and by the top level ports.
// ----------------------------------------------------------------------

`default_nettype none

package oflow_score_pkg;

	// SAD score width.
	// a 64 word block of four lanes sums to at most 64*4*255 = 65280.
	localparam int SCORE_W = 16; // fits blocks of up to 64 words.

	// candidate index width.
	// candidates per search stay below 256.
	localparam int INDEX_W = 8; // index of the winning candidate.

endpackage

`default_nettype wire

// ==== hw/oflow_similarity_metric.sv ====
// ----------------------------------------------------------------------
// Sum of absolute differences over one candidate block.
// Words of cur_pix / ref_pix arrive on pix_valid; pix_last closes the
// candidate. Score and done strobe appear one cycle after the last word.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module oflow_similarity_metric (
	input  logic                                clk,
	input  logic                                reset_N,
	input  logic                                search_start, // clears the accumulator.
	input  logic                                pix_valid,    // one word pair this cycle.
	input  logic                                pix_last,     // final word of the candidate.
	input  logic [oflow_core_pkg::WORD_W-1:0]   cur_pix,
	input  logic [oflow_core_pkg::WORD_W-1:0]   ref_pix,
	output logic                                done_similarity_metric,
	output logic [oflow_score_pkg::SCORE_W-1:0] cand_score
);

	// four 8 bit differences need two extra bits.
	localparam int SUM_W = oflow_core_pkg::PIX_W + $clog2(oflow_core_pkg::LANES);

	logic [SUM_W-1:0]                    word_sad; // SAD of the current word.
	logic [oflow_score_pkg::SCORE_W-1:0] acc;      // running sum of the candidate.
	logic [oflow_score_pkg::SCORE_W-1:0] acc_next; // sum including this word.

	// absolute difference of two unsigned pixels.
	function automatic logic [oflow_core_pkg::PIX_W-1:0] abs_diff(
		input logic [oflow_core_pkg::PIX_W-1:0] a,
		input logic [oflow_core_pkg::PIX_W-1:0] b
	);
		if (a > b) begin
			return a - b;
		end
		return b - a;
	endfunction

	// lane by lane difference, summed into one word score.
	always_comb begin
		word_sad = '0;
		for (int l = 0; l < oflow_core_pkg::LANES; l++) begin
			word_sad = word_sad + SUM_W'(abs_diff(
				cur_pix[l*oflow_core_pkg::PIX_W +: oflow_core_pkg::PIX_W],
				ref_pix[l*oflow_core_pkg::PIX_W +: oflow_core_pkg::PIX_W]));
		end
	end

	assign acc_next = acc + oflow_score_pkg::SCORE_W'(word_sad); // no wrap within 64 words.

	// accumulator and done strobe.
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			acc                    <= '0;
			done_similarity_metric <= 1'b0;
		end else begin
			done_similarity_metric <= 1'b0; // strobe by default.
			if (search_start) begin
				acc <= '0; // fresh search.
			end else if (pix_valid) begin
				if (pix_last) begin
					acc                    <= '0;   // next candidate starts clean.
					done_similarity_metric <= 1'b1; // score ready next cycle.
				end else begin
					acc <= acc_next;
				end
			end
		end
	end

	// score register, loaded with the closing sum.
	always_ff @(posedge clk) begin
		if (pix_valid && pix_last && !search_start) begin
			cand_score <= acc_next; // valid with the done strobe.
		end
	end

	// the word strobe must be known once out of reset.
	a_pix_valid_known: assert property (
		@(posedge clk) disable iff (!reset_N)
		!$isunknown(pix_valid)
	) else $error("pix_valid is X after reset");

endmodule

`default_nettype wire

// ==== hw/oflow_score_calc_calc_min_fsm.sv ====
// ----------------------------------------------------------------------
// Pairing controller of the score stage.
// Waits for the first score of a pair and fires start_calc_min when
// the second one arrives; done_calc_min returns it to idle.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module oflow_score_calc_calc_min_fsm (
	input  logic clk,
	input  logic reset_N,
	input  logic done_calc_min,          // end of search from the minimum block.
	input  logic done_similarity_metric, // one candidate score ready.
	output logic start_calc_min          // second score of a pair present.
);

	typedef enum logic {idle_st, calc_min_st} state_t;

	state_t current_state;
	state_t next_state;

	// state register.
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			current_state <= idle_st;
		end else begin
			current_state <= next_state;
		end
	end

	// next state and start pulse.
	always_comb begin
		next_state     = current_state;
		start_calc_min = 1'b0;
		case (current_state)
			idle_st: begin
				if (done_similarity_metric) begin
					next_state = calc_min_st; // first score of the pair held.
				end
			end
			calc_min_st: begin
				if (done_similarity_metric) begin
					start_calc_min = 1'b1; // same cycle as the second score.
					next_state     = idle_st;
				end
			end
			default: next_state = idle_st;
		endcase
		if (done_calc_min) begin
			next_state = idle_st; // search over, drop any pairing.
		end
	end

	// the result follows a completed pair, so pairing is idle by then.
	a_done_in_idle: assert property (
		@(posedge clk) disable iff (!reset_N)
		done_calc_min |-> (current_state == idle_st)
	) else $error("done_calc_min while a pair is open");

endmodule

`default_nettype wire

// ==== hw/oflow_score_calc_calc_min.sv ====
// ----------------------------------------------------------------------
// Running minimum over candidate scores, two at a time.
// Holds the first score of each pair; on start_calc_min compares it and
// the incoming score against the best so far. After the last pair the
// result is loaded and done_calc_min pulses for one cycle.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module oflow_score_calc_calc_min #(
	parameter int NUM_CAND = 8 // even, 2 to 254.
) (
	input  logic                                clk,
	input  logic                                reset_N,
	input  logic                                search_start,
	input  logic                                done_similarity_metric,
	input  logic                                start_calc_min,
	input  logic [oflow_score_pkg::SCORE_W-1:0] cand_score,
	output logic                                done_calc_min,
	output logic [oflow_score_pkg::SCORE_W-1:0] best_score,
	output logic [oflow_score_pkg::INDEX_W-1:0] best_index
);

	localparam int PAIR_W = oflow_score_pkg::INDEX_W - 1; // index without its low bit.
	localparam logic [PAIR_W-1:0] LAST_PAIR = PAIR_W'(NUM_CAND / 2 - 1);

	logic [oflow_score_pkg::SCORE_W-1:0] held_score; // first score of the pair.
	logic [PAIR_W-1:0]                   pair_cnt;   // pairs finished this search.
	logic [oflow_score_pkg::SCORE_W-1:0] run_score;  // best so far.
	logic [oflow_score_pkg::INDEX_W-1:0] run_index;
	logic [oflow_score_pkg::SCORE_W-1:0] pick_score; // best after this pair.
	logic [oflow_score_pkg::INDEX_W-1:0] pick_index;
	logic                                last_pair;

	assign last_pair = (pair_cnt == LAST_PAIR);

	// older candidates are checked first so ties keep the lower index.
	always_comb begin
		pick_score = run_score;
		pick_index = run_index;
		if (held_score < pick_score) begin
			pick_score = held_score;
			pick_index = {pair_cnt, 1'b0}; // even candidate.
		end
		if (cand_score < pick_score) begin
			pick_score = cand_score;
			pick_index = {pair_cnt, 1'b1}; // odd candidate.
		end
	end

	// each score is held; only the one opening a pair is read later.
	always_ff @(posedge clk) begin
		if (done_similarity_metric) begin
			held_score <= cand_score;
		end
	end

	// running best and pair count.
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			pair_cnt      <= '0;
			run_score     <= '1;
			run_index     <= '0;
			done_calc_min <= 1'b0;
		end else begin
			done_calc_min <= 1'b0;
			if (search_start) begin
				pair_cnt  <= '0;
				run_score <= '1; // anything real beats the maximum.
				run_index <= '0;
			end else if (start_calc_min) begin
				pair_cnt      <= pair_cnt + 1'b1;
				run_score     <= pick_score;
				run_index     <= pick_index;
				done_calc_min <= last_pair; // result with the update.
			end
		end
	end

	// result registers, stable until the next search completes.
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			best_score <= '0;
			best_index <= '0;
		end else if (start_calc_min && last_pair && !search_start) begin
			best_score <= pick_score;
			best_index <= pick_index;
		end
	end

	// a pair can only close on a fresh score from the metric.
	a_start_with_score: assert property (
		@(posedge clk) disable iff (!reset_N)
		start_calc_min |-> done_similarity_metric
	) else $error("start_calc_min without a score strobe");

endmodule

`default_nettype wire

// ==== hw/oflow_score_calc.sv ====
// ----------------------------------------------------------------------
// Score stage top level of the optical-flow block matcher.
// Streams word pairs through the SAD metric, pairs the scores and keeps
// the minimum. best_valid strobes two cycles after the last word of the
// last candidate, with best_score / best_index held afterwards.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module oflow_score_calc #(
	parameter int NUM_CAND = 8 // candidates per search, even.
) (
	input  logic                                clk,
	input  logic                                reset_N,
	input  logic                                search_start,
	input  logic                                pix_valid,
	input  logic                                pix_last,
	input  logic [oflow_core_pkg::WORD_W-1:0]   cur_pix,
	input  logic [oflow_core_pkg::WORD_W-1:0]   ref_pix,
	output logic                                best_valid,
	output logic [oflow_score_pkg::SCORE_W-1:0] best_score,
	output logic [oflow_score_pkg::INDEX_W-1:0] best_index
);

	logic                                done_similarity_metric; // score strobe.
	logic [oflow_score_pkg::SCORE_W-1:0] cand_score;
	logic                                start_calc_min;         // second of a pair.
	logic                                done_calc_min;          // search result ready.

	oflow_similarity_metric u_similarity_metric (
		.clk                    (clk),
		.reset_N                (reset_N),
		.search_start           (search_start),
		.pix_valid              (pix_valid),
		.pix_last               (pix_last),
		.cur_pix                (cur_pix),
		.ref_pix                (ref_pix),
		.done_similarity_metric (done_similarity_metric),
		.cand_score             (cand_score)
	);

	oflow_score_calc_calc_min_fsm u_calc_min_fsm (
		.clk                    (clk),
		.reset_N                (reset_N),
		.done_calc_min          (done_calc_min),
		.done_similarity_metric (done_similarity_metric),
		.start_calc_min         (start_calc_min)
	);

	oflow_score_calc_calc_min #(
		.NUM_CAND (NUM_CAND)
	) u_calc_min (
		.clk                    (clk),
		.reset_N                (reset_N),
		.search_start           (search_start),
		.done_similarity_metric (done_similarity_metric),
		.start_calc_min         (start_calc_min),
		.cand_score             (cand_score),
		.done_calc_min          (done_calc_min),
		.best_score             (best_score),
		.best_index             (best_index)
	);

	assign best_valid = done_calc_min; // result strobe.

endmodule

`default_nettype wire

// ==== test/oflow_score_calc_tb.sv ====
// ----------------------------------------------------------------------
// Testbench of the optical-flow score stage.
// Streams LFSR driven searches through the DUT, models each SAD and the
// first minimum, and checks result value, index and timing with
// concurrent assertions. Ends with the error counts and a verdict.
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module oflow_score_calc_tb;

	localparam int NUM_CAND       = 8;
	localparam int MAX_LEN        = 8;  // words per candidate block.
	localparam int RESULT_TIMEOUT = 64; // cycles allowed for best_valid.
	localparam int NUM_SEARCH     = 8;
	localparam int M_RANDOM       = 0;
	localparam int M_SMALL        = 1;  // diffs 0..3 per pixel.
	localparam int M_LARGE        = 2;  // diffs 128..131 per pixel.
	localparam int M_ZERO_TIE     = 3;  // candidates 5..7 match exactly.
	localparam int M_EQUAL_TIE    = 4;  // candidates 2, 3, 6 share the low SAD.

	logic                                clk = 1'b0;
	logic                                reset_N;
	logic                                search_start;
	logic                                pix_valid;
	logic                                pix_last;
	logic [oflow_core_pkg::WORD_W-1:0]   cur_pix;
	logic [oflow_core_pkg::WORD_W-1:0]   ref_pix;
	logic                                best_valid;
	logic [oflow_score_pkg::SCORE_W-1:0] best_score;
	logic [oflow_score_pkg::INDEX_W-1:0] best_index;

	logic [31:0] lfsr;                         // stimulus source.
	logic [31:0] cur_mem [NUM_CAND][MAX_LEN];  // current block words.
	logic [31:0] ref_mem [NUM_CAND][MAX_LEN];  // candidate block words.
	int          blk_len [NUM_CAND];
	logic [oflow_score_pkg::SCORE_W-1:0] exp_score;
	logic [oflow_score_pkg::INDEX_W-1:0] exp_index;
	logic [oflow_score_pkg::SCORE_W-1:0] held_score_q = '0; // model result of the last search.
	logic [oflow_score_pkg::INDEX_W-1:0] held_index_q = '0;
	logic        final_word = 1'b0; // tags the last word of the last candidate.
	logic        final_d1   = 1'b0;
	logic        final_d2   = 1'b0;
	string       test_name  = "reset";
	int          result_cnt    = 0;
	int          searches_sent = 0;
	int          value_errs    = 0;
	int          timing_errs   = 0;
	int          timeout_errs  = 0;
	int          mode_seq [NUM_SEARCH] = '{M_RANDOM, M_RANDOM, M_ZERO_TIE, M_EQUAL_TIE,
		M_RANDOM, M_SMALL, M_LARGE, M_RANDOM}; // small then large checks the restart.

	always #2 clk = ~clk; // 4 ns period.

	oflow_score_calc #(
		.NUM_CAND (NUM_CAND)
	) u_oflow_score_calc (
		.clk          (clk),
		.reset_N      (reset_N),
		.search_start (search_start),
		.pix_valid    (pix_valid),
		.pix_last     (pix_last),
		.cur_pix      (cur_pix),
		.ref_pix      (ref_pix),
		.best_valid   (best_valid),
		.best_score   (best_score),
		.best_index   (best_index)
	);

	// result bookkeeping, sampled on the clock.
	always @(posedge clk) begin
		final_d1 <= final_word;
		final_d2 <= final_d1; // two cycles after the final word.
		if (reset_N && best_valid) begin
			result_cnt   <= result_cnt + 1;
			held_score_q <= exp_score;
			held_index_q <= exp_index;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) !reset_N |-> !best_valid)
		else begin
			timing_errs++;
			$display("CHECK FAILED: reset_quiet best_valid expected 0 actual %0b",
				$sampled(best_valid));
		end

	// one strobe per search, exactly two cycles after its final word.
	a_result_timing: assert property (@(posedge clk) disable iff (!reset_N)
		best_valid == final_d2)
		else begin
			timing_errs++;
			$display("CHECK FAILED: %s best_valid expected %0b actual %0b",
				test_name, $sampled(final_d2), $sampled(best_valid));
		end

	a_best_score: assert property (@(posedge clk) disable iff (!reset_N)
		best_valid |-> best_score == exp_score)
		else begin
			value_errs++;
			$display("CHECK FAILED: %s best_score expected %0d actual %0d",
				test_name, exp_score, $sampled(best_score));
		end

	a_best_index: assert property (@(posedge clk) disable iff (!reset_N)
		best_valid |-> best_index == exp_index)
		else begin
			value_errs++;
			$display("CHECK FAILED: %s best_index expected %0d actual %0d",
				test_name, exp_index, $sampled(best_index));
		end

	// outputs keep the last result between strobes.
	a_result_held: assert property (@(posedge clk) disable iff (!reset_N)
		!best_valid |-> best_score == held_score_q && best_index == held_index_q)
		else begin
			value_errs++;
			$display("CHECK FAILED: %s held score/index expected %0d/%0d actual %0d/%0d",
				test_name, held_score_q, held_index_q, $sampled(best_score),
				$sampled(best_index));
		end

	// fibonacci LFSR, taps 32 22 2 1, one step per bit taken.
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic string mode_name(input int mode);
		case (mode)
			M_SMALL:     return "small_sad";
			M_LARGE:     return "large_sad";
			M_ZERO_TIE:  return "zero_tie";
			M_EQUAL_TIE: return "equal_tie";
			default:     return "random";
		endcase
	endfunction

	// fills cur_mem, ref_mem and blk_len for one search.
	task automatic build_search(input int mode);
		logic [7:0] lc;
		logic [7:0] lr;
		for (int k = 0; k < NUM_CAND; k++) begin
			blk_len[k] = int'(lfsr_bits(3)) + 1;
			if (mode == M_EQUAL_TIE) begin
				blk_len[k] = 2; // equal lengths give equal SADs.
			end
			for (int w = 0; w < blk_len[k]; w++) begin
				for (int l = 0; l < oflow_core_pkg::LANES; l++) begin
					case (mode)
						M_SMALL: begin
							lc = 8'(lfsr_bits(6));
							lr = lc + 8'(lfsr_bits(2));
						end
						M_LARGE: begin
							lc = 8'(lfsr_bits(6));
							lr = lc + 8'd128 + 8'(lfsr_bits(2));
						end
						M_ZERO_TIE: begin
							lc = 8'(lfsr_bits(8));
							lr = (k >= 5) ? lc : 8'(lfsr_bits(8));
						end
						M_EQUAL_TIE: begin
							lc = 8'h40;
							lr = (k == 2 || k == 3 || k == 6) ? 8'h41 : 8'h48;
						end
						default: begin
							lc = 8'(lfsr_bits(8));
							lr = 8'(lfsr_bits(8));
						end
					endcase
					cur_mem[k][w][l*8 +: 8] = lc;
					ref_mem[k][w][l*8 +: 8] = lr;
				end
			end
		end
	endtask

	// reference model: SAD per candidate, first strict minimum wins.
	task automatic compute_expected();
		int sad;
		int a;
		int b;
		exp_score = '1;
		exp_index = '0;
		for (int k = 0; k < NUM_CAND; k++) begin
			sad = 0;
			for (int w = 0; w < blk_len[k]; w++) begin
				for (int l = 0; l < oflow_core_pkg::LANES; l++) begin
					a   = int'(cur_mem[k][w][l*8 +: 8]);
					b   = int'(ref_mem[k][w][l*8 +: 8]);
					sad = sad + ((a > b) ? a - b : b - a);
				end
			end
			if (sad < int'(exp_score)) begin
				exp_score = sad[15:0];
				exp_index = k[7:0];
			end
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		search_start <= 1'b0;
		pix_valid    <= 1'b0;
		pix_last     <= 1'b0;
		final_word   <= 1'b0;
	endtask

	task automatic start_pulse();
		@(posedge clk);
		search_start <= 1'b1;
		pix_valid    <= 1'b0;
		pix_last     <= 1'b0;
		final_word   <= 1'b0;
	endtask

	task automatic send_word(input logic [31:0] c, input logic [31:0] r,
		input logic last, input logic fin);
		@(posedge clk);
		search_start <= 1'b0;
		pix_valid    <= 1'b1;
		pix_last     <= last;
		cur_pix      <= c;
		ref_pix      <= r;
		final_word   <= fin;
	endtask

	// idles until the result of the current search has been counted.
	task automatic wait_result(output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < RESULT_TIMEOUT) begin
			idle_cycle();
			n++;
			if (result_cnt == searches_sent) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			timeout_errs++;
			$display("timeout: no best_valid within %0d cycles in search %s",
				RESULT_TIMEOUT, test_name);
		end
	endtask

	task automatic run_search(input int mode, output bit ok);
		build_search(mode);
		compute_expected();
		test_name = mode_name(mode);
		start_pulse();
		for (int k = 0; k < NUM_CAND; k++) begin
			for (int w = 0; w < blk_len[k]; w++) begin
				repeat (int'(lfsr_bits(2))) idle_cycle(); // random gap.
				send_word(cur_mem[k][w], ref_mem[k][w], w == blk_len[k] - 1,
					(k == NUM_CAND - 1) && (w == blk_len[k] - 1));
			end
		end
		searches_sent++;
		wait_result(ok);
	endtask

	initial begin
		bit ok;
		reset_N      = 1'b0;
		search_start = 1'b0;
		pix_valid    = 1'b0;
		pix_last     = 1'b0;
		cur_pix      = '0;
		ref_pix      = '0;
		lfsr         = 32'h0d80127b;
		ok           = 1'b1;
		repeat (16) @(posedge clk);
		reset_N <= 1'b1;
		repeat (4) idle_cycle(); // quiet window after reset.
		for (int s = 0; s < NUM_SEARCH && ok; s++) begin
			run_search(mode_seq[s], ok);
		end
		repeat (4) idle_cycle();
		$display("errors: value %0d timing %0d timeout %0d",
			value_errs, timing_errs, timeout_errs);
		if (value_errs + timing_errs + timeout_errs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/oflow_core_pkg.sv
hw/oflow_score_pkg.sv
hw/oflow_similarity_metric.sv
hw/oflow_score_calc_calc_min_fsm.sv
hw/oflow_score_calc_calc_min.sv
hw/oflow_score_calc.sv
test/oflow_score_calc_tb.sv

// ==== Bender.yml ====
package:
  name: oflow_score_calc

sources:
  # packages first, then leaf modules, then the top level.
  - files:
      - hw/oflow_core_pkg.sv
      - hw/oflow_score_pkg.sv
      - hw/oflow_similarity_metric.sv
      - hw/oflow_score_calc_calc_min_fsm.sv
      - hw/oflow_score_calc_calc_min.sv
      - hw/oflow_score_calc.sv

  # testbench, top module oflow_score_calc_tb.
  - target: test
    files:
      - test/oflow_score_calc_tb.sv
